/* coproc_top.f */
+incdir+include
logic/coproc_pkg.sv
logic/mod_arith_unit.sv
logic/data_mem_arbiter.sv
logic/inst_fetch.sv
logic/exec_sequencer.sv
logic/coproc_top.sv
verification/coproc_tb.sv

/* logic/coproc_pkg.sv */
// Shared widths and types; module ELEM_BITS must not exceed DAT_BITS, ARITH_LAT must be 3 or more
package coproc_pkg;

  // Default element width and memory address width
  localparam int DAT_BITS  = 16;
  localparam int ADDR_BITS = 8;

  // Fixed pipeline latencies seen by the sequencer
  localparam int ARITH_LAT  = 3;
  localparam int RAM_RD_LAT = 1;

  typedef enum logic [2:0] {
    HALT        = 3'd0,
    COPY_REG    = 3'd1,
    ADD_ELEMENT = 3'd2,
    SUB_ELEMENT = 3'd3,
    MUL_ELEMENT = 3'd4
  } opcode_e;

  typedef enum logic [1:0] {
    ARITH_ADD = 2'd0,
    ARITH_SUB = 2'd1,
    ARITH_MUL = 2'd2
  } arith_op_e;

  // Copy moves a to b, arithmetic writes op(a, b) to c
  typedef struct packed {
    opcode_e              code;
    logic [ADDR_BITS-1:0] a;
    logic [ADDR_BITS-1:0] b;
    logic [ADDR_BITS-1:0] c;
  } inst_t;

  localparam int INST_BITS = $bits(inst_t);

  typedef struct packed {
    logic                 we;
    logic [ADDR_BITS-1:0] addr;
    logic [DAT_BITS-1:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    arith_op_e           op;
    logic [DAT_BITS-1:0] x;
    logic [DAT_BITS-1:0] y;
  } arith_req_t;

endpackage

/* logic/coproc_top.sv */
// i_host_sel high targets instruction memory (write only); data writes use the low DAT_BITS bits
`timescale 1ns/10ps

module coproc_top
  import coproc_pkg::*;
#(
  parameter int                   ELEM_BITS = DAT_BITS,
  parameter logic [ELEM_BITS-1:0] P         = 65521
)(
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_host_stb,
  input  logic                 i_host_sel,
  input  logic                 i_host_we,
  input  logic [ADDR_BITS-1:0] i_host_addr,
  input  logic [INST_BITS-1:0] i_host_wdata,
  input  logic                 i_start,
  input  logic [ADDR_BITS-1:0] i_start_pt,
  output logic [DAT_BITS-1:0]  o_host_rdata,
  output logic                 o_host_rvalid,
  output logic                 o_busy,
  output logic                 o_done
);

  logic                start_acc;
  logic                inst_wr_stb;
  logic                data_stb;
  mem_req_t            host_req;
  logic                next_stb;
  inst_t               inst;
  logic                inst_vld;
  logic                core_stb;
  mem_req_t            core_req;
  logic                core_gnt;
  logic [DAT_BITS-1:0] core_rdata;
  logic                core_rvalid;
  logic                arith_stb;
  arith_req_t          arith_req;
  logic                res_vld;
  logic [DAT_BITS-1:0] res_dat;

  // Start is dropped while a program runs
  always_comb begin
    start_acc   = i_start && !o_busy;
    inst_wr_stb = i_host_stb && i_host_sel && i_host_we;
    data_stb    = i_host_stb && !i_host_sel;
    host_req    = '{we: i_host_we, addr: i_host_addr, wdata: i_host_wdata[DAT_BITS-1:0]};
  end

  inst_fetch inst_fetch_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr_stb   (inst_wr_stb),
    .i_wr_addr  (i_host_addr),
    .i_wr_inst  (inst_t'(i_host_wdata)),
    .i_start    (start_acc),
    .i_start_pt (i_start_pt),
    .i_next_stb (next_stb),
    .o_inst     (inst),
    .o_inst_vld (inst_vld)
  );

  exec_sequencer exec_sequencer_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start      (start_acc),
    .o_next_stb   (next_stb),
    .i_inst       (inst),
    .i_inst_vld   (inst_vld),
    .o_mem_stb    (core_stb),
    .o_mem_req    (core_req),
    .i_mem_gnt    (core_gnt),
    .i_mem_rdata  (core_rdata),
    .i_mem_rvalid (core_rvalid),
    .o_arith_stb  (arith_stb),
    .o_arith_req  (arith_req),
    .i_arith_vld  (res_vld),
    .i_arith_dat  (res_dat),
    .o_busy       (o_busy),
    .o_done       (o_done)
  );

  mod_arith_unit #(
    .ELEM_BITS (ELEM_BITS),
    .P         (P)
  ) mod_arith_unit_inst (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_stb (arith_stb),
    .i_req (arith_req),
    .o_vld (res_vld),
    .o_dat (res_dat)
  );

  data_mem_arbiter #(
    .ELEM_BITS (ELEM_BITS)
  ) data_mem_arbiter_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_host_stb    (data_stb),
    .i_host_req    (host_req),
    .o_host_rdata  (o_host_rdata),
    .o_host_rvalid (o_host_rvalid),
    .i_core_stb    (core_stb),
    .i_core_req    (core_req),
    .o_core_gnt    (core_gnt),
    .o_core_rdata  (core_rdata),
    .o_core_rvalid (core_rvalid)
  );

endmodule

/* logic/data_mem_arbiter.sv */
// Host always wins the single port; data memory has no reset and stores ELEM_BITS per word
`timescale 1ns/10ps

module data_mem_arbiter
  import coproc_pkg::*;
#(
  parameter int ELEM_BITS = DAT_BITS
)(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_host_stb,
  input  mem_req_t            i_host_req,
  output logic [DAT_BITS-1:0] o_host_rdata,
  output logic                o_host_rvalid,
  input  logic                i_core_stb,
  input  mem_req_t            i_core_req,
  output logic                o_core_gnt,
  output logic [DAT_BITS-1:0] o_core_rdata,
  output logic                o_core_rvalid
);

  logic [ELEM_BITS-1:0]  ram [2**ADDR_BITS];
  logic [ELEM_BITS-1:0]  rd_q [RAM_RD_LAT];
  logic [RAM_RD_LAT-1:0] host_rd_sr;
  logic [RAM_RD_LAT-1:0] core_rd_sr;
  mem_req_t              sel_req;
  logic                  sel_stb;

  // Host strobe always takes the port from the core
  always_comb begin
    o_core_gnt = i_core_stb && !i_host_stb;
    sel_stb    = i_host_stb || i_core_stb;
    sel_req    = i_host_stb ? i_host_req : i_core_req;
  end

  // Read-first port where granted writes land at this edge
  always_ff @(posedge i_clk) begin
    if (sel_stb && sel_req.we) begin
      ram[sel_req.addr] <= sel_req.wdata[ELEM_BITS-1:0];
    end
    rd_q[0] <= ram[sel_req.addr];
    for (int i = 1; i < RAM_RD_LAT; i++) begin
      rd_q[i] <= rd_q[i-1];
    end
  end

  // Read valid follows whoever owned the port
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      host_rd_sr <= '0;
      core_rd_sr <= '0;
    end else begin
      host_rd_sr <= (host_rd_sr << 1) | RAM_RD_LAT'(i_host_stb && !i_host_req.we);
      core_rd_sr <= (core_rd_sr << 1) | RAM_RD_LAT'(o_core_gnt && !i_core_req.we);
    end
  end

  assign o_host_rvalid = host_rd_sr[RAM_RD_LAT-1];
  assign o_core_rvalid = core_rd_sr[RAM_RD_LAT-1];
  assign o_host_rdata  = DAT_BITS'(rd_q[RAM_RD_LAT-1]);
  assign o_core_rdata  = DAT_BITS'(rd_q[RAM_RD_LAT-1]);

  // A refused core request stays up with the same target
  a_core_held: assert property (@(posedge i_clk) disable iff (i_rst)
    i_core_stb && !o_core_gnt |=> i_core_stb && $stable({i_core_req.we, i_core_req.addr}));

endmodule

/* logic/exec_sequencer.sv */
// One instruction at a time; unknown opcodes are skipped and HALT returns to idle
`timescale 1ns/10ps

module exec_sequencer
  import coproc_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  output logic                o_next_stb,
  input  inst_t               i_inst,
  input  logic                i_inst_vld,
  output logic                o_mem_stb,
  output mem_req_t            o_mem_req,
  input  logic                i_mem_gnt,
  input  logic [DAT_BITS-1:0] i_mem_rdata,
  input  logic                i_mem_rvalid,
  output logic                o_arith_stb,
  output arith_req_t          o_arith_req,
  input  logic                i_arith_vld,
  input  logic [DAT_BITS-1:0] i_arith_dat,
  output logic                o_busy,
  output logic                o_done
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_FETCH,
    S_DECODE,
    S_RD_A,
    S_WAIT_A,
    S_RD_B,
    S_WAIT_B,
    S_WAIT_RES,
    S_WRITE
  } state_e;

  state_e              state;
  inst_t               inst_q;
  logic [DAT_BITS-1:0] opa_q;
  logic [DAT_BITS-1:0] res_q;

  function automatic arith_op_e op_map(input opcode_e code);
    case (code)
      SUB_ELEMENT: return ARITH_SUB;
      MUL_ELEMENT: return ARITH_MUL;
      default:     return ARITH_ADD;
    endcase
  endfunction

  // Request is held steady until the arbiter grants it
  always_comb begin
    o_next_stb      = (state == S_FETCH);
    o_mem_stb       = (state == S_RD_A) || (state == S_RD_B) || (state == S_WRITE);
    o_mem_req.we    = (state == S_WRITE);
    o_mem_req.wdata = res_q;
    case (state)
      S_RD_B:  o_mem_req.addr = inst_q.b;
      S_WRITE: o_mem_req.addr = (inst_q.code == COPY_REG) ? inst_q.b : inst_q.c;
      default: o_mem_req.addr = inst_q.a;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= S_IDLE;
      o_busy      <= 1'b0;
      o_done      <= 1'b0;
      o_arith_stb <= 1'b0;
    end else begin
      o_done      <= 1'b0;
      o_arith_stb <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            state  <= S_FETCH;
            o_busy <= 1'b1;
          end
        end
        S_FETCH: state <= S_DECODE;
        S_DECODE: begin
          if (i_inst_vld) begin
            case (i_inst.code)
              HALT: begin
                state  <= S_IDLE;
                o_busy <= 1'b0;
                o_done <= 1'b1;
              end
              COPY_REG, ADD_ELEMENT, SUB_ELEMENT, MUL_ELEMENT: state <= S_RD_A;
              default: state <= S_FETCH;
            endcase
          end
        end
        S_RD_A: if (i_mem_gnt) state <= S_WAIT_A;
        // Copy skips operand b and the arithmetic
        S_WAIT_A: if (i_mem_rvalid) state <= (inst_q.code == COPY_REG) ? S_WRITE : S_RD_B;
        S_RD_B: if (i_mem_gnt) state <= S_WAIT_B;
        S_WAIT_B: begin
          if (i_mem_rvalid) begin
            o_arith_stb <= 1'b1;
            state       <= S_WAIT_RES;
          end
        end
        S_WAIT_RES: if (i_arith_vld) state <= S_WRITE;
        S_WRITE: if (i_mem_gnt) state <= S_FETCH;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Instruction and operand holding registers
  always_ff @(posedge i_clk) begin
    if (state == S_DECODE && i_inst_vld) begin
      inst_q <= i_inst;
    end
    if (state == S_WAIT_A && i_mem_rvalid) begin
      opa_q <= i_mem_rdata;
      res_q <= i_mem_rdata;
    end
    if (state == S_WAIT_B && i_mem_rvalid) begin
      o_arith_req <= '{op: op_map(inst_q.code), x: opa_q, y: i_mem_rdata};
    end
    if (state == S_WAIT_RES && i_arith_vld) begin
      res_q <= i_arith_dat;
    end
  end

  // Only one operation is ever outstanding from this FSM
  a_result_expected: assert property (@(posedge i_clk) disable iff (i_rst)
    i_arith_vld |-> state == S_WAIT_RES);

endmodule

/* logic/inst_fetch.sv */
// Instruction memory has no reset and is loaded by the host; the pointer wraps at the memory end
`timescale 1ns/10ps

module inst_fetch
  import coproc_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_wr_stb,
  input  logic [ADDR_BITS-1:0] i_wr_addr,
  input  inst_t                i_wr_inst,
  input  logic                 i_start,
  input  logic [ADDR_BITS-1:0] i_start_pt,
  input  logic                 i_next_stb,
  output inst_t                o_inst,
  output logic                 o_inst_vld
);

  inst_t                imem [2**ADDR_BITS];
  logic [ADDR_BITS-1:0] inst_pt;

  // Host writes may arrive at any time
  always_ff @(posedge i_clk) begin
    if (i_wr_stb) begin
      imem[i_wr_addr] <= i_wr_inst;
    end
    if (i_next_stb) begin
      o_inst <= imem[inst_pt];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      inst_pt    <= '0;
      o_inst_vld <= 1'b0;
    end else begin
      o_inst_vld <= i_next_stb;
      // Start reloads, each fetch steps by one
      if (i_start) begin
        inst_pt <= i_start_pt;
      end else if (i_next_stb) begin
        inst_pt <= inst_pt + 1'b1;
      end
    end
  end

endmodule

/* logic/mod_arith_unit.sv */
// Operands must be below P; results are zero-extended to DAT_BITS and valid ARITH_LAT cycles later
`timescale 1ns/10ps

module mod_arith_unit
  import coproc_pkg::*;
#(
  parameter int                   ELEM_BITS = DAT_BITS,
  parameter logic [ELEM_BITS-1:0] P         = 65521
)(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_stb,
  input  arith_req_t          i_req,
  output logic                o_vld,
  output logic [DAT_BITS-1:0] o_dat
);

  localparam int W2 = 2 * ELEM_BITS;

  logic [W2-1:0]        x_ext;
  logic [W2-1:0]        y_ext;
  logic [W2-1:0]        p_ext;
  arith_op_e            s1_op;
  logic [W2-1:0]        s1_raw;
  logic [W2-1:0]        red;
  logic [ELEM_BITS-1:0] s2_red;
  logic [ELEM_BITS-1:0] out_q [ARITH_LAT-2];
  logic [ARITH_LAT-1:0] vld_sr;

  always_comb begin
    x_ext = W2'(i_req.x[ELEM_BITS-1:0]);
    y_ext = W2'(i_req.y[ELEM_BITS-1:0]);
    p_ext = W2'(P);
  end

  // Stage one, difference offset by P so it never goes negative
  always_ff @(posedge i_clk) begin
    s1_op <= i_req.op;
    case (i_req.op)
      ARITH_SUB: s1_raw <= x_ext + p_ext - y_ext;
      ARITH_MUL: s1_raw <= x_ext * y_ext;
      default:   s1_raw <= x_ext + y_ext;
    endcase
  end

  // Sum and offset difference stay below 2P, one subtract is enough
  always_comb begin
    if (s1_op == ARITH_MUL) begin
      red = s1_raw % p_ext;
    end else if (s1_raw >= p_ext) begin
      red = s1_raw - p_ext;
    end else begin
      red = s1_raw;
    end
  end

  // Stage two holds the reduced value, then the output stages
  always_ff @(posedge i_clk) begin
    s2_red   <= red[ELEM_BITS-1:0];
    out_q[0] <= s2_red;
    for (int i = 1; i < ARITH_LAT - 2; i++) begin
      out_q[i] <= out_q[i-1];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[ARITH_LAT-2:0], i_stb};
    end
  end

  assign o_vld = vld_sr[ARITH_LAT-1];
  assign o_dat = DAT_BITS'(out_q[ARITH_LAT-3]);

  // Reduced operands keep every stage within its 2P bound
  a_operands_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    i_stb |-> (i_req.x[ELEM_BITS-1:0] < P) && (i_req.y[ELEM_BITS-1:0] < P));

endmodule

/* include/coproc_tb_tasks.svh */
// Tasks begin and end on a falling clock edge; the model expects operands already below MOD_P
`ifndef COPROC_TB_TASKS_SVH
`define COPROC_TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    error_count++;
    $display("** Error %s: expected %0d, actual %0d at %0t", name, expected, actual, $time);
  end
endtask

task automatic host_write(input logic sel, input logic [ADDR_BITS-1:0] addr,
                          input logic [INST_BITS-1:0] wdata);
  i_host_stb   = 1'b1;
  i_host_sel   = sel;
  i_host_we    = 1'b1;
  i_host_addr  = addr;
  i_host_wdata = wdata;
  @(negedge i_clk);
  i_host_stb = 1'b0;
  i_host_we  = 1'b0;
endtask

// Read data is due one cycle after the strobe
task automatic host_read(input string name, input logic [ADDR_BITS-1:0] addr,
                         output logic [DAT_BITS-1:0] rdata);
  i_host_stb  = 1'b1;
  i_host_sel  = 1'b0;
  i_host_we   = 1'b0;
  i_host_addr = addr;
  @(negedge i_clk);
  i_host_stb = 1'b0;
  check_value({name, " rvalid"}, 1, o_host_rvalid);
  rdata = o_host_rdata;
endtask

task automatic set_data(input logic [ADDR_BITS-1:0] addr, input logic [DAT_BITS-1:0] value);
  host_write(1'b0, addr, INST_BITS'(value));
  model_mem[addr] = value;
endtask

task automatic check_data(input string name, input logic [ADDR_BITS-1:0] addr);
  logic [DAT_BITS-1:0] rdata;
  host_read(name, addr, rdata);
  check_value($sformatf("%s addr %0d", name, addr), model_mem[addr], rdata);
endtask

// Loads one instruction word, apply steps the model in program order
task automatic put_inst(input logic [ADDR_BITS-1:0] pt, input opcode_e code,
                        input logic [ADDR_BITS-1:0] a, input logic [ADDR_BITS-1:0] b,
                        input logic [ADDR_BITS-1:0] c, input bit apply);
  host_write(1'b1, pt, {code, a, b, c});
  if (apply) begin
    case (code)
      COPY_REG:    model_mem[b] = model_mem[a];
      ADD_ELEMENT: model_mem[c] = add_mod(model_mem[a], model_mem[b]);
      SUB_ELEMENT: model_mem[c] = sub_mod(model_mem[a], model_mem[b]);
      MUL_ELEMENT: model_mem[c] = mul_mod(model_mem[a], model_mem[b]);
      default: ;
    endcase
  end
endtask

task automatic run_program(input string name, input logic [ADDR_BITS-1:0] pt);
  i_start    = 1'b1;
  i_start_pt = pt;
  @(negedge i_clk);
  i_start = 1'b0;
  check_value({name, " busy"}, 1, o_busy);
  while (o_done !== 1'b1) begin
    @(negedge i_clk);
  end
  // Busy drops on the same edge as done
  check_value({name, " idle"}, 0, o_busy);
endtask

task automatic data_readback();
  for (int i = 0; i < 16; i++) begin
    set_data(ADDR_BITS'(i), DAT_BITS'($urandom));
  end
  for (int i = 0; i < 16; i++) begin
    check_data("data_readback", ADDR_BITS'(i));
  end
endtask

task automatic add_sub_ops();
  logic [DAT_BITS-1:0] same;
  same = rand_elem();
  set_data(8'd16, rand_elem());
  set_data(8'd17, rand_elem());
  set_data(8'd18, MOD_P - 16'd1);
  set_data(8'd19, MOD_P - 16'd2);
  set_data(8'd20, 16'd5);
  set_data(8'd21, 16'd9);
  set_data(8'd22, same);
  set_data(8'd23, same);
  put_inst(8'd0, ADD_ELEMENT, 8'd16, 8'd17, 8'd32, 1'b1);
  put_inst(8'd1, SUB_ELEMENT, 8'd16, 8'd17, 8'd33, 1'b1);
  put_inst(8'd2, ADD_ELEMENT, 8'd18, 8'd19, 8'd34, 1'b1);
  put_inst(8'd3, SUB_ELEMENT, 8'd20, 8'd21, 8'd35, 1'b1);
  put_inst(8'd4, SUB_ELEMENT, 8'd22, 8'd23, 8'd36, 1'b1);
  put_inst(8'd5, HALT, 8'd0, 8'd0, 8'd0, 1'b1);
  run_program("add_sub_ops", 8'd0);
  for (int i = 32; i <= 36; i++) begin
    check_data("add_sub_ops", ADDR_BITS'(i));
  end
endtask

task automatic mul_ops();
  set_data(8'd40, rand_elem());
  set_data(8'd41, rand_elem());
  set_data(8'd42, MOD_P - 16'd1);
  set_data(8'd43, rand_elem());
  set_data(8'd44, 16'd1);
  put_inst(8'd8, MUL_ELEMENT, 8'd40, 8'd41, 8'd48, 1'b1);
  put_inst(8'd9, MUL_ELEMENT, 8'd42, 8'd42, 8'd49, 1'b1);
  put_inst(8'd10, MUL_ELEMENT, 8'd43, 8'd44, 8'd50, 1'b1);
  put_inst(8'd11, HALT, 8'd0, 8'd0, 8'd0, 1'b1);
  run_program("mul_ops", 8'd8);
  for (int i = 48; i <= 50; i++) begin
    check_data("mul_ops", ADDR_BITS'(i));
  end
endtask

// Each step feeds on earlier results, copies move a to b
task automatic chained_program();
  for (int i = 64; i < 68; i++) begin
    set_data(ADDR_BITS'(i), rand_elem());
  end
  put_inst(8'd16, ADD_ELEMENT, 8'd64, 8'd65, 8'd70, 1'b1);
  put_inst(8'd17, MUL_ELEMENT, 8'd70, 8'd66, 8'd71, 1'b1);
  put_inst(8'd18, COPY_REG, 8'd71, 8'd72, 8'd0, 1'b1);
  put_inst(8'd19, SUB_ELEMENT, 8'd72, 8'd67, 8'd73, 1'b1);
  put_inst(8'd20, MUL_ELEMENT, 8'd73, 8'd73, 8'd74, 1'b1);
  put_inst(8'd21, ADD_ELEMENT, 8'd74, 8'd70, 8'd75, 1'b1);
  put_inst(8'd22, SUB_ELEMENT, 8'd64, 8'd75, 8'd76, 1'b1);
  put_inst(8'd23, COPY_REG, 8'd76, 8'd77, 8'd0, 1'b1);
  put_inst(8'd24, MUL_ELEMENT, 8'd77, 8'd71, 8'd78, 1'b1);
  put_inst(8'd25, ADD_ELEMENT, 8'd78, 8'd78, 8'd79, 1'b1);
  put_inst(8'd26, HALT, 8'd0, 8'd0, 8'd0, 1'b1);
  run_program("chained_program", 8'd16);
  for (int i = 70; i < 80; i++) begin
    check_data("chained_program", ADDR_BITS'(i));
  end
endtask

task automatic traffic_during_run();
  for (int i = 96; i < 100; i++) begin
    set_data(ADDR_BITS'(i), rand_elem());
  end
  put_inst(8'd32, MUL_ELEMENT, 8'd96, 8'd97, 8'd104, 1'b1);
  put_inst(8'd33, ADD_ELEMENT, 8'd104, 8'd98, 8'd105, 1'b1);
  put_inst(8'd34, SUB_ELEMENT, 8'd105, 8'd99, 8'd106, 1'b1);
  put_inst(8'd35, MUL_ELEMENT, 8'd106, 8'd106, 8'd107, 1'b1);
  put_inst(8'd36, HALT, 8'd0, 8'd0, 8'd0, 1'b1);
  fork
    run_program("traffic_during_run", 8'd32);
    begin
      // Random gaps let host and core grants interleave
      for (int i = 0; i < 8; i++) begin
        repeat ($urandom % 3) @(negedge i_clk);
        set_data(ADDR_BITS'(128 + i), DAT_BITS'($urandom));
      end
      for (int i = 0; i < 8; i++) begin
        repeat ($urandom % 3) @(negedge i_clk);
        check_data("traffic_during_run", ADDR_BITS'(128 + i));
        check_data("traffic_during_run", ADDR_BITS'(i));
      end
    end
  join
  for (int i = 104; i < 108; i++) begin
    check_data("traffic_during_run", ADDR_BITS'(i));
  end
endtask

task automatic restart_pointer();
  set_data(8'd140, rand_elem());
  set_data(8'd141, rand_elem());
  set_data(8'd150, rand_elem());
  set_data(8'd151, rand_elem());
  set_data(8'd160, rand_elem());
  put_inst(8'd48, ADD_ELEMENT, 8'd140, 8'd141, 8'd145, 1'b1);
  put_inst(8'd49, HALT, 8'd0, 8'd0, 8'd0, 1'b1);
  run_program("restart_pointer first", 8'd48);
  // New operands would change 145 if the first program ran again
  set_data(8'd140, rand_elem());
  set_data(8'd141, rand_elem());
  put_inst(8'd56, MUL_ELEMENT, 8'd150, 8'd151, 8'd155, 1'b1);
  put_inst(8'd57, HALT, 8'd0, 8'd0, 8'd0, 1'b1);
  put_inst(8'd58, SUB_ELEMENT, 8'd150, 8'd151, 8'd160, 1'b0);
  run_program("restart_pointer second", 8'd56);
  check_data("restart_pointer", 8'd145);
  check_data("restart_pointer", 8'd155);
  check_data("restart_pointer", 8'd160);
endtask

`endif

/* verification/coproc_tb.sv */
// Runs the DUT with 16-bit elements and P of 65521; both memories start unknown and are loaded here
`timescale 1ns/10ps

module coproc_tb
  import coproc_pkg::*;
();

  localparam int          ELEM_W = 16;
  localparam logic [15:0] MOD_P  = 16'd65521;
  localparam int unsigned SEED   = 32'h3008_3cb1;

  // Per test instructions (HALT included) and host strobes
  localparam int INST_TOTAL     = 0 + 6 + 4 + 11 + 5 + 4;
  localparam int ACCESS_TOTAL   = 32 + 19 + 12 + 25 + 37 + 15;
  localparam int TIMEOUT_CYCLES = 4 * (5 * INST_TOTAL + ACCESS_TOTAL) + 200;

  logic                 i_clk;
  logic                 i_rst;
  logic                 i_host_stb;
  logic                 i_host_sel;
  logic                 i_host_we;
  logic [ADDR_BITS-1:0] i_host_addr;
  logic [INST_BITS-1:0] i_host_wdata;
  logic                 i_start;
  logic [ADDR_BITS-1:0] i_start_pt;
  logic [DAT_BITS-1:0]  o_host_rdata;
  logic                 o_host_rvalid;
  logic                 o_busy;
  logic                 o_done;

  logic [DAT_BITS-1:0] model_mem [2**ADDR_BITS];
  int                  error_count = 0;
  int                  cycle_count = 0;

  // Reference arithmetic straight from the field rules
  function automatic logic [DAT_BITS-1:0] add_mod(input logic [DAT_BITS-1:0] x,
                                                  input logic [DAT_BITS-1:0] y);
    return DAT_BITS'((64'(x) + 64'(y)) % 64'(MOD_P));
  endfunction

  function automatic logic [DAT_BITS-1:0] sub_mod(input logic [DAT_BITS-1:0] x,
                                                  input logic [DAT_BITS-1:0] y);
    longint diff;
    diff = longint'(x) - longint'(y);
    if (diff < 0) begin
      diff = diff + longint'(MOD_P);
    end
    return DAT_BITS'(diff);
  endfunction

  function automatic logic [DAT_BITS-1:0] mul_mod(input logic [DAT_BITS-1:0] x,
                                                  input logic [DAT_BITS-1:0] y);
    return DAT_BITS'((64'(x) * 64'(y)) % 64'(MOD_P));
  endfunction

  function automatic logic [DAT_BITS-1:0] rand_elem();
    return DAT_BITS'($urandom % MOD_P);
  endfunction

  `include "coproc_tb_tasks.svh"

  coproc_top #(
    .ELEM_BITS (ELEM_W),
    .P         (MOD_P)
  ) coproc_top_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_host_stb    (i_host_stb),
    .i_host_sel    (i_host_sel),
    .i_host_we     (i_host_we),
    .i_host_addr   (i_host_addr),
    .i_host_wdata  (i_host_wdata),
    .i_start       (i_start),
    .i_start_pt    (i_start_pt),
    .o_host_rdata  (o_host_rdata),
    .o_host_rvalid (o_host_rvalid),
    .o_busy        (o_busy),
    .o_done        (o_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // Watchdog on total cycles
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles before the tests finished", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    i_rst        = 1'b1;
    i_host_stb   = 1'b0;
    i_host_sel   = 1'b0;
    i_host_we    = 1'b0;
    i_host_addr  = '0;
    i_host_wdata = '0;
    i_start      = 1'b0;
    i_start_pt   = '0;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    check_value("reset", 0, {o_busy, o_done, o_host_rvalid});

    data_readback();
    add_sub_ops();
    mul_ops();
    chained_program();
    traffic_during_run();
    restart_pointer();

    $display("Checks finished with %0d errors after %0d cycles", error_count, cycle_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
